// ==== files.f ====
logic/rx_ctrl_pkg.sv
logic/err_pkt_pkg.sv
logic/cmd_if.sv
logic/sync_fifo.sv
logic/cmd_queue.sv
logic/rx_sequencer.sv
logic/err_reporter.sv
logic/rx_control_top.sv
bench/rx_control_tb.sv

// ==== bench/rx_control_tb.sv ====
`timescale 1ns/100ps

module rx_control_tb;

   localparam int TIMEOUT = 2000; // Cycles allowed for any single wait.

   logic                   clk;
   logic                   i_reset;
   logic                   i_set_stb;
   rx_ctrl_pkg::set_addr_t i_set_addr;
   rx_ctrl_pkg::set_data_t i_set_data;
   rx_ctrl_pkg::time_t     i_vita_time = 64'h1000;
   logic                   i_strobe;
   logic                   i_full;
   err_pkt_pkg::seqnum_t   i_seqnum;
   err_pkt_pkg::sid_t      i_sid;
   logic                   o_run;
   logic                   o_eob;
   logic [63:0]            o_err_tdata;
   logic                   o_err_tlast;
   logic                   o_err_tvalid;
   logic                   i_err_tready;

   logic [31:0] rng = 32'h8b07_a728;
   logic        strobe_en;
   logic        tready_low;  // Holds the error stream off.
   logic        tready_rand;
   logic        run_q;
   int          line_cnt = 0;
   int          eob_cnt = 0;
   int          eob_line = 0;
   int          run_rises = 0;
   int          pkt_cnt = 0;
   int          beat_idx = 0;
   int          errs = 0;
   int          n_cmds = 0;
   rx_ctrl_pkg::time_t last_time = '0;

   // Every command written in order.
   logic [31:0]        cmd_words [32];
   rx_ctrl_pkg::time_t cmd_times [32];

   // Packets still to arrive on the error stream.
   err_pkt_pkg::err_code_t exp_code [$];
   err_pkt_pkg::seqnum_t   exp_seq [$];
   err_pkt_pkg::sid_t      exp_sid [$];
   rx_ctrl_pkg::time_t     exp_time [$];

   rx_control_top rx_control_top_i (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   // Expected {error code, lines} of a burst that starts at command first.
   // A reloading chain gives the lines of one round.
   function automatic logic [63:0] ref_burst(input int first, input int count, input logic late);
      logic [31:0]            word;
      logic [31:0]            lines;
      err_pkt_pkg::err_code_t code;
      logic                   done;
      int                     i;
      lines = '0;
      code  = '0;
      done  = 1'b0;
      for (i = first; i < first + count && !done; i++) begin
         word = cmd_words[i];
         if (word[28]) begin
            done = 1'b1; // Stop ends the burst ahead of its own lines.
         end else if (i == first && late && !word[31]) begin
            code = err_pkt_pkg::ERR_LATE_CMD;
            done = 1'b1;
         end else begin
            lines = lines + word[27:0];
            if (!word[30]) done = 1'b1;
            else if (i == first + count - 1 && !word[29]) code = err_pkt_pkg::ERR_BROKEN_CHAIN;
         end
      end
      return {code, lines};
   endfunction

   // Radio time, random strobes and random ready.
   always @(posedge clk) begin
      rng          <= xorshift(rng);
      i_vita_time  <= i_vita_time + 1'b1;
      i_strobe     <= strobe_en && (rng[1:0] != 2'b00);
      i_err_tready <= !tready_low && (!tready_rand || rng[7]);
   end

   always @(posedge clk) begin
      run_q <= o_run;
      if (!i_reset) begin
         if (o_run && i_strobe && !i_full) line_cnt <= line_cnt + 1;
         if (o_eob) begin
            eob_cnt  <= eob_cnt + 1;
            eob_line <= line_cnt + 1; // Line that carried the end of burst.
         end
         if (o_run && !run_q) run_rises <= run_rises + 1;
         if (o_eob && !(o_run && i_strobe)) begin
            $display("o_eob was high without a strobe in a running burst at %0t", $time);
            errs++;
         end
      end
   end

   task automatic report_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
      errs++;
   endtask

   always @(posedge clk) begin : compare_stream
      logic [63:0] hdr;
      if (!i_reset && o_err_tvalid && i_err_tready) begin
         if (exp_code.size() == 0) begin
            $display("An error packet beat arrived while no packet was expected");
            errs++;
         end else begin
            hdr = {err_pkt_pkg::ERR_HDR_FLAGS, exp_seq[0], err_pkt_pkg::ERR_PKT_BYTES, exp_sid[0]};
            if (o_err_tlast != (beat_idx == 2))
               report_mismatch("o_err_tlast", o_err_tlast, beat_idx == 2);
            case (beat_idx)
               0: if (o_err_tdata != hdr) report_mismatch("o_err_tdata header", o_err_tdata, hdr);
               1: begin
                  if (o_err_tdata < exp_time[0])
                     report_mismatch("o_err_tdata time, minimum", o_err_tdata, exp_time[0]);
                  if (o_err_tdata <= last_time) begin
                     $display("Error packet time 0x%h does not follow 0x%h", o_err_tdata, last_time);
                     errs++;
                  end
                  last_time = o_err_tdata;
               end
               default: begin
                  if (o_err_tdata != {exp_code[0], 32'h0})
                     report_mismatch("o_err_tdata code", o_err_tdata, {exp_code[0], 32'h0});
                  void'(exp_code.pop_front());
                  void'(exp_seq.pop_front());
                  void'(exp_sid.pop_front());
                  void'(exp_time.pop_front());
                  pkt_cnt <= pkt_cnt + 1;
               end
            endcase
         end
         beat_idx = (beat_idx == 2) ? 0 : beat_idx + 1;
      end
   end

   task automatic write_setting(input rx_ctrl_pkg::set_addr_t addr,
                                input rx_ctrl_pkg::set_data_t data);
      @(posedge clk);
      i_set_stb  <= 1'b1;
      i_set_addr <= addr;
      i_set_data <= data;
      @(posedge clk);
      i_set_stb <= 1'b0;
   endtask

   // Flags are {imm, chain, reload, stop}.
   task automatic push_cmd(input logic [3:0] flags, input rx_ctrl_pkg::lines_t lines,
                           input rx_ctrl_pkg::time_t start);
      cmd_words[n_cmds] = {flags, lines};
      cmd_times[n_cmds] = start;
      n_cmds++;
      write_setting(rx_ctrl_pkg::SET_ADDR_CMD, {flags, lines});
      write_setting(rx_ctrl_pkg::SET_ADDR_TIME_HI, start[63:32]);
      write_setting(rx_ctrl_pkg::SET_ADDR_TIME_LO, start[31:0]); // Enqueues.
   endtask

   task automatic expect_pkt(input err_pkt_pkg::err_code_t code, input rx_ctrl_pkg::time_t start);
      exp_code.push_back(code);
      exp_seq.push_back(i_seqnum);
      exp_sid.push_back(i_sid);
      exp_time.push_back(start);
   endtask

   task automatic start_test(input int id);
      @(posedge clk);
      strobe_en <= 1'b0;
      i_seqnum  <= id[11:0];
      i_sid     <= 32'h5d00_0000 | id;
      repeat (4) @(posedge clk);
   endtask

   task automatic wait_run(input logic level);
      int n;
      n = 0;
      @(posedge clk);
      while (o_run !== level && n < TIMEOUT) begin
         @(posedge clk);
         n++;
      end
      if (o_run !== level) begin
         $display("Timed out waiting for o_run to become %0b", level);
         errs++;
      end
   endtask

   task automatic wait_lines(input int target);
      int n;
      n = 0;
      @(posedge clk);
      while (line_cnt < target && n < TIMEOUT) begin
         @(posedge clk);
         n++;
      end
      if (line_cnt < target) begin
         $display("Timed out waiting for %0d burst lines, saw %0d", target, line_cnt);
         errs++;
      end
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      @(posedge clk);
      while (exp_code.size() != 0 && n < TIMEOUT) begin
         @(posedge clk);
         n++;
      end
      if (exp_code.size() != 0) begin
         $display("Timed out with %0d error packets still missing", exp_code.size());
         errs++;
      end
   endtask

   // Runs one burst from command first with random strobes and checks it.
   task automatic run_burst(input int first, input int count);
      logic [63:0] res;
      int          lines0;
      int          eobs0;
      res = ref_burst(first, count, 1'b0);
      if (res[63:32] != 0) expect_pkt(res[63:32], cmd_times[first]);
      lines0 = line_cnt;
      eobs0  = eob_cnt;
      strobe_en <= 1'b1;
      wait_run(1'b1);
      if (!cmd_words[first][31] &&
          (i_vita_time <= cmd_times[first] || i_vita_time > cmd_times[first] + 4)) begin
         $display("o_run rose at time 0x%h for start time 0x%h", i_vita_time, cmd_times[first]);
         errs++;
      end
      wait_run(1'b0);
      strobe_en <= 1'b0;
      repeat (3) @(posedge clk);
      if (line_cnt - lines0 != res[31:0])
         report_mismatch("i_strobe lines in burst", line_cnt - lines0, res[31:0]);
      if (eob_cnt - eobs0 != 1) report_mismatch("o_eob count", eob_cnt - eobs0, 1);
      if (eob_line - lines0 != res[31:0])
         report_mismatch("o_eob line in burst", eob_line - lines0, res[31:0]);
      wait_drain();
   endtask

   initial begin : main_flow
      int                 first;
      int                 k;
      int                 lines0;
      int                 eobs0;
      int                 rises0;
      int                 round;
      logic [63:0]        res;
      rx_ctrl_pkg::time_t start;
      i_reset     <= 1'b1;
      i_set_stb   <= 1'b0;
      i_set_addr  <= '0;
      i_set_data  <= '0;
      i_strobe    <= 1'b0;
      i_full      <= 1'b0;
      i_seqnum    <= '0;
      i_sid       <= '0;
      i_err_tready <= 1'b1;
      strobe_en   <= 1'b0;
      tready_low  <= 1'b0;
      tready_rand <= 1'b0;
      repeat (3) @(posedge clk);
      i_reset <= 1'b0;
      @(posedge clk);
      if (o_run !== 1'b0 || o_eob !== 1'b0 || o_err_tvalid !== 1'b0) begin
         $display("Outputs are not all low after reset");
         errs++;
      end

      start_test(1); // Immediate burst.
      first = n_cmds;
      push_cmd(4'b1000, 28'd7, '0);
      run_burst(first, 1);

      start_test(2); // Timed burst.
      first = n_cmds;
      push_cmd(4'b0000, 28'd5, i_vita_time + 40);
      run_burst(first, 1);

      start_test(3); // Late command gives no run.
      first  = n_cmds;
      rises0 = run_rises;
      start  = i_vita_time - 5;
      push_cmd(4'b0000, 28'd4, start);
      res = ref_burst(first, 1, 1'b1);
      expect_pkt(res[63:32], start);
      wait_drain();
      if (run_rises != rises0) report_mismatch("o_run rises", run_rises, rises0);

      start_test(4); // Overrun.
      push_cmd(4'b1000, 28'd20, '0);
      expect_pkt(err_pkt_pkg::ERR_OVERRUN, '0);
      eobs0 = eob_cnt;
      strobe_en <= 1'b1;
      wait_lines(line_cnt + 5);
      strobe_en <= 1'b0;
      repeat (3) @(posedge clk);
      lines0 = line_cnt;
      i_full    <= 1'b1;
      strobe_en <= 1'b1;
      wait_run(1'b0);
      strobe_en <= 1'b0;
      i_full    <= 1'b0;
      wait_drain();
      if (line_cnt != lines0) report_mismatch("i_strobe lines after overrun", line_cnt, lines0);
      if (eob_cnt != eobs0) report_mismatch("o_eob count after overrun", eob_cnt, eobs0);

      start_test(5); // Two chained commands and then a broken chain.
      first = n_cmds;
      push_cmd(4'b1100, 28'd5, '0);
      push_cmd(4'b0000, 28'd6, '0);
      run_burst(first, 2);
      first = n_cmds;
      push_cmd(4'b1100, 28'd5, '0);
      run_burst(first, 1);

      start_test(6); // Reload until halt discards the queued command.
      first = n_cmds;
      push_cmd(4'b1110, 28'd4, '0);
      res    = ref_burst(first, 1, 1'b0);
      round  = res[31:0];
      lines0 = line_cnt;
      eobs0  = eob_cnt;
      strobe_en <= 1'b1;
      wait_lines(lines0 + 3 * round);
      strobe_en <= 1'b0;
      repeat (3) @(posedge clk);
      write_setting(rx_ctrl_pkg::SET_ADDR_HALT, 32'h1);
      push_cmd(4'b1000, 28'd3, '0);
      repeat (4) @(posedge clk);
      rises0 = run_rises;
      strobe_en <= 1'b1;
      wait_run(1'b0);
      strobe_en <= 1'b0;
      repeat (20) @(posedge clk);
      if ((line_cnt - lines0) % round != 0 || line_cnt - lines0 < 3 * round) begin
         $display("Reload burst ran %0d lines, not whole rounds of %0d", line_cnt - lines0, round);
         errs++;
      end
      if (eob_cnt - eobs0 != 1) report_mismatch("o_eob count at halt", eob_cnt - eobs0, 1);
      if (eob_line != line_cnt) report_mismatch("o_eob line at halt", eob_line, line_cnt);
      if (run_rises != rises0) report_mismatch("o_run rises after halt", run_rises, rises0);

      start_test(7); // Late commands under back-pressure.
      tready_low <= 1'b1;
      for (k = 0; k < 8; k++) begin
         first = n_cmds;
         start = i_vita_time - 100 + k;
         push_cmd(4'b0000, 28'd2, start);
         res = ref_burst(first, 1, 1'b1);
         expect_pkt(res[63:32], start);
      end
      repeat (30) @(posedge clk);
      if (o_err_tvalid !== 1'b1 || o_run !== 1'b0) begin
         $display("Error stream is not stalled with valid data under back-pressure");
         errs++;
      end
      tready_low  <= 1'b0;
      tready_rand <= 1'b1;
      wait_drain();
      tready_rand <= 1'b0;
      repeat (10) @(posedge clk);

      $display("Errors: %0d, error packets: %0d, bursts ended: %0d", errs, pkt_cnt, eob_cnt);
      if (errs == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

// ==== logic/rx_control_top.sv ====
`timescale 1ns/100ps

module rx_control_top (
   input  logic                    clk,
   input  logic                    i_reset,
   input  logic                    i_set_stb,
   input  rx_ctrl_pkg::set_addr_t  i_set_addr,
   input  rx_ctrl_pkg::set_data_t  i_set_data,
   input  rx_ctrl_pkg::time_t      i_vita_time,
   input  logic                    i_strobe,  // Sample strobe from the DDC.
   input  logic                    i_full,    // Downstream framing FIFO is full.
   input  err_pkt_pkg::seqnum_t    i_seqnum,
   input  err_pkt_pkg::sid_t       i_sid,
   output logic                    o_run,
   output logic                    o_eob,
   output logic [63:0]             o_err_tdata,
   output logic                    o_err_tlast,
   output logic                    o_err_tvalid,
   input  logic                    i_err_tready
);

   logic                   err_req;
   logic                   err_ack;
   err_pkt_pkg::err_code_t err_code;

   cmd_if cmd_bus ();

   cmd_queue u_cmd_queue (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_set_stb  (i_set_stb),
      .i_set_addr (i_set_addr),
      .i_set_data (i_set_data),
      .cmd        (cmd_bus.queue)
   );

   rx_sequencer u_rx_sequencer (
      .clk         (clk),
      .i_reset     (i_reset),
      .cmd         (cmd_bus.seq),
      .i_vita_time (i_vita_time),
      .i_strobe    (i_strobe),
      .i_full      (i_full),
      .o_run       (o_run),
      .o_eob       (o_eob),
      .o_err_req   (err_req),
      .o_err_code  (err_code),
      .i_err_ack   (err_ack)
   );

   err_reporter u_err_reporter (
      .clk          (clk),
      .i_reset      (i_reset),
      .i_err_req    (err_req),
      .i_err_code   (err_code),
      .o_err_ack    (err_ack),
      .i_vita_time  (i_vita_time),
      .i_seqnum     (i_seqnum),
      .i_sid        (i_sid),
      .o_err_tdata  (o_err_tdata),
      .o_err_tlast  (o_err_tlast),
      .o_err_tvalid (o_err_tvalid),
      .i_err_tready (i_err_tready)
   );

endmodule

// ==== logic/err_reporter.sv ====
`timescale 1ns/100ps

module err_reporter (
   input  logic                    clk,
   input  logic                    i_reset,
   input  logic                    i_err_req,
   input  err_pkt_pkg::err_code_t  i_err_code,
   output logic                    o_err_ack,
   input  logic [63:0]             i_vita_time,
   input  err_pkt_pkg::seqnum_t    i_seqnum,
   input  err_pkt_pkg::sid_t       i_sid,
   output logic [63:0]             o_err_tdata,
   output logic                    o_err_tlast,
   output logic                    o_err_tvalid,
   input  logic                    i_err_tready
);

   logic [1:0]                 beat_cnt;  // Zero when no packet is being written.
   logic [63:0]                hdr_q;
   logic [63:0]                time_q;
   err_pkt_pkg::err_code_t     code_q;
   logic [63:0]                beat_data;
   logic                       beat_last;
   logic                       beat_valid;
   logic [err_pkt_pkg::ERR_FIFO_LOG2:0] free;

   // Take a request only when the whole packet fits.
   assign o_err_ack = i_err_req && (beat_cnt == 2'd0) && (free >= 3);

   always_ff @(posedge clk) begin
      if (o_err_ack) begin
         hdr_q  <= {err_pkt_pkg::ERR_HDR_FLAGS, i_seqnum, err_pkt_pkg::ERR_PKT_BYTES, i_sid};
         time_q <= i_vita_time; // Time of acceptance.
         code_q <= i_err_code;
      end
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         beat_cnt <= 2'd0;
      end else if (o_err_ack) begin
         beat_cnt <= 2'd1;
      end else if (beat_cnt == 2'd3) begin
         beat_cnt <= 2'd0;
      end else if (beat_cnt != 2'd0) begin
         beat_cnt <= beat_cnt + 2'd1;
      end
   end

   always_comb begin
      case (beat_cnt)
         2'd1:    beat_data = hdr_q;
         2'd2:    beat_data = time_q;
         2'd3:    beat_data = {code_q, 32'b0};
         default: beat_data = 64'b0;
      endcase
   end

   assign beat_valid = (beat_cnt != 2'd0);
   assign beat_last  = (beat_cnt == 2'd3);

   sync_fifo #(
      .WIDTH (65),
      .LOG2  (err_pkt_pkg::ERR_FIFO_LOG2)
   ) u_out_fifo (
      .clk     (clk),
      .i_reset (i_reset),
      .i_clear (1'b0),
      .i_data  ({beat_last, beat_data}),
      .i_valid (beat_valid),
      .o_ready (),
      .o_data  ({o_err_tlast, o_err_tdata}),
      .o_valid (o_err_tvalid),
      .i_ready (i_err_tready && o_err_tvalid),
      .o_free  (free)
   );

   // Three beats go out before the next request can be taken.
   a_no_ack_mid_packet: assert property (@(posedge clk) disable iff (i_reset)
      o_err_ack |=> !o_err_ack [*3])
      else $error("error request acknowledged during a packet");

endmodule

// ==== logic/rx_sequencer.sv ====
`timescale 1ns/100ps

module rx_sequencer (
   input  logic                    clk,
   input  logic                    i_reset,
   cmd_if.seq                      cmd,
   input  rx_ctrl_pkg::time_t      i_vita_time,
   input  logic                    i_strobe,
   input  logic                    i_full,
   output logic                    o_run,
   output logic                    o_eob,
   output logic                    o_err_req,
   output err_pkt_pkg::err_code_t  o_err_code,
   input  logic                    i_err_ack
);

   rx_ctrl_pkg::seq_state_t state;
   rx_ctrl_pkg::lines_t     lines_left;
   rx_ctrl_pkg::lines_t     repeat_lines; // Count restored on reload.
   logic                    chain_sav;
   logic                    reload_sav;

   logic now;
   logic late;
   logic in_run;
   logic last_line;
   logic line_end;
   logic idle_take;
   logic idle_start;
   logic idle_late;
   logic chain_take;
   logic reload_now;
   logic broken;
   logic overrun;
   logic load_cmd;
   logic continues;

   // Time compare against the head command.
   assign now  = (i_vita_time == cmd.rx_time);
   assign late = (i_vita_time > cmd.rx_time);

   assign in_run    = (state == rx_ctrl_pkg::RUNNING);
   assign last_line = (lines_left == 28'd1);
   assign line_end  = in_run && i_strobe && !i_full && last_line;
   assign overrun   = in_run && i_strobe && i_full;

   // Decode of the head command while idle.
   assign idle_take  = (state == rx_ctrl_pkg::IDLE) && cmd.valid;
   assign idle_late  = idle_take && !cmd.stop && late && !cmd.send_imm;
   assign idle_start = idle_take && !cmd.stop && !idle_late && (now || cmd.send_imm);

   // End of burst rules, halt first.
   assign cmd.flush  = line_end && cmd.halt;
   assign chain_take = line_end && !cmd.halt && chain_sav && cmd.valid;
   assign reload_now = line_end && !cmd.halt && chain_sav && !cmd.valid && reload_sav;
   assign broken     = line_end && !cmd.halt && chain_sav && !cmd.valid && !reload_sav;

   assign continues = (chain_take && !cmd.stop) || reload_now;
   assign load_cmd  = idle_start || chain_take;
   assign o_eob     = line_end && !continues;

   assign cmd.ready = (idle_take && (cmd.stop || late || now || cmd.send_imm)) || chain_take;

   always_ff @(posedge clk) begin
      if (load_cmd) begin
         lines_left   <= cmd.num_lines;
         repeat_lines <= cmd.num_lines;
      end else if (reload_now) begin
         lines_left <= repeat_lines;
      end else if (in_run && i_strobe && !i_full && !last_line) begin
         lines_left <= lines_left - 1'b1;
      end

      if (overrun) begin
         o_err_code <= err_pkt_pkg::ERR_OVERRUN;
      end else if (broken) begin
         o_err_code <= err_pkt_pkg::ERR_BROKEN_CHAIN;
      end else if (idle_late) begin
         o_err_code <= err_pkt_pkg::ERR_LATE_CMD;
      end
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         state      <= rx_ctrl_pkg::IDLE;
         o_run      <= 1'b0;
         o_err_req  <= 1'b0;
         chain_sav  <= 1'b0;
         reload_sav <= 1'b0;
      end else begin
         if (load_cmd) begin
            chain_sav  <= cmd.chain;
            reload_sav <= cmd.reload;
         end

         case (state)
            rx_ctrl_pkg::IDLE: begin
               if (idle_start) begin
                  state <= rx_ctrl_pkg::RUNNING;
                  o_run <= 1'b1;
               end else if (idle_late) begin
                  state     <= rx_ctrl_pkg::ERR_WAIT;
                  o_err_req <= 1'b1;
               end
            end

            rx_ctrl_pkg::RUNNING: begin
               if (overrun || broken) begin
                  state     <= rx_ctrl_pkg::ERR_WAIT;
                  o_run     <= 1'b0;
                  o_err_req <= 1'b1;
               end else if (line_end && !continues) begin
                  state <= rx_ctrl_pkg::IDLE; // Plain end, halt or chained stop.
                  o_run <= 1'b0;
               end
            end

            rx_ctrl_pkg::ERR_WAIT: begin
               if (i_err_ack) begin
                  state     <= rx_ctrl_pkg::IDLE;
                  o_err_req <= 1'b0;
               end
            end

            default: begin
               state     <= rx_ctrl_pkg::IDLE;
               o_run     <= 1'b0;
               o_err_req <= 1'b0;
            end
         endcase
      end
   end

   a_run_in_running: assert property (@(posedge clk) disable iff (i_reset)
      o_run |-> (state == rx_ctrl_pkg::RUNNING))
      else $error("o_run outside RUNNING");

   // The request stays up until the reporter takes it.
   a_err_req_held: assert property (@(posedge clk) disable iff (i_reset)
      o_err_req |-> (state == rx_ctrl_pkg::ERR_WAIT) ##1 (o_err_req || $past(i_err_ack)))
      else $error("err_req outside ERR_WAIT or dropped before ack");

endmodule

// ==== logic/cmd_queue.sv ====
`timescale 1ns/100ps

module cmd_queue (
   input  logic                   clk,
   input  logic                   i_reset,
   input  logic                   i_set_stb,
   input  rx_ctrl_pkg::set_addr_t i_set_addr,
   input  rx_ctrl_pkg::set_data_t i_set_data,
   cmd_if.queue                   cmd
);

   rx_ctrl_pkg::set_data_t  cmd_word_q; // Staged flags and line count.
   rx_ctrl_pkg::set_data_t  time_hi_q;
   rx_ctrl_pkg::set_data_t  time_lo_q;
   logic                    store_q;    // Push pulse, one cycle after TIME_LO.
   rx_ctrl_pkg::cmd_word_t  head;
   rx_ctrl_pkg::set_data_t  head_cmd;
   logic                    wr_cmd;
   logic                    wr_time_hi;
   logic                    wr_time_lo;
   logic                    wr_halt;

   assign wr_cmd     = i_set_stb && (i_set_addr == rx_ctrl_pkg::SET_ADDR_CMD);
   assign wr_time_hi = i_set_stb && (i_set_addr == rx_ctrl_pkg::SET_ADDR_TIME_HI);
   assign wr_time_lo = i_set_stb && (i_set_addr == rx_ctrl_pkg::SET_ADDR_TIME_LO);
   assign wr_halt    = i_set_stb && (i_set_addr == rx_ctrl_pkg::SET_ADDR_HALT);

   always_ff @(posedge clk) begin
      if (wr_cmd)     cmd_word_q <= i_set_data;
      if (wr_time_hi) time_hi_q  <= i_set_data;
      if (wr_time_lo) time_lo_q  <= i_set_data;
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         store_q  <= 1'b0;
         cmd.halt <= 1'b0;
      end else begin
         store_q <= wr_time_lo;
         if (cmd.flush) begin
            cmd.halt <= 1'b0; // Cleared on the same edge as the queue.
         end else if (wr_halt) begin
            cmd.halt <= 1'b1;
         end
      end
   end

   sync_fifo #(
      .WIDTH ($bits(rx_ctrl_pkg::cmd_word_t)),
      .LOG2  (rx_ctrl_pkg::CMD_FIFO_LOG2)
   ) u_cmd_fifo (
      .clk     (clk),
      .i_reset (i_reset),
      .i_clear (cmd.flush),
      .i_data  ({cmd_word_q, time_hi_q, time_lo_q}),
      .i_valid (store_q),
      .o_ready (),
      .o_data  (head),
      .o_valid (cmd.valid),
      .i_ready (cmd.ready),
      .o_free  ()
   );

   // Split the head entry into its fields.
   assign head_cmd      = head[95:64];
   assign cmd.send_imm  = head_cmd[rx_ctrl_pkg::CMD_BIT_IMM];
   assign cmd.chain     = head_cmd[rx_ctrl_pkg::CMD_BIT_CHAIN];
   assign cmd.reload    = head_cmd[rx_ctrl_pkg::CMD_BIT_RELOAD];
   assign cmd.stop      = head_cmd[rx_ctrl_pkg::CMD_BIT_STOP];
   assign cmd.num_lines = head_cmd[27:0];
   assign cmd.rx_time   = head[63:0];

endmodule

// ==== logic/sync_fifo.sv ====
`timescale 1ns/100ps

module sync_fifo #(
   parameter int WIDTH = 8,
   parameter int LOG2  = 4
) (
   input  logic             clk,
   input  logic             i_reset,
   input  logic             i_clear,
   input  logic [WIDTH-1:0] i_data,
   input  logic             i_valid,
   output logic             o_ready,
   output logic [WIDTH-1:0] o_data,
   output logic             o_valid,
   input  logic             i_ready,
   output logic [LOG2:0]    o_free
);

   localparam logic [LOG2:0] DEPTH = {1'b1, {LOG2{1'b0}}};

   logic [WIDTH-1:0] mem [DEPTH];
   logic [LOG2:0]    wr_ptr;
   logic [LOG2:0]    rd_ptr;
   logic [LOG2:0]    count;
   logic             do_write;
   logic             do_read;

   assign count    = wr_ptr - rd_ptr; // Extra pointer bit tells full from empty.
   assign o_ready  = (count != DEPTH);
   assign o_valid  = (count != '0);
   assign o_free   = DEPTH - count;
   assign o_data   = mem[rd_ptr[LOG2-1:0]]; // Head falls through.
   assign do_write = i_valid && o_ready;
   assign do_read  = o_valid && i_ready;

   always_ff @(posedge clk) begin
      if (i_reset || i_clear) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (do_write) wr_ptr <= wr_ptr + 1'b1;
         if (do_read)  rd_ptr <= rd_ptr + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (do_write) mem[wr_ptr[LOG2-1:0]] <= i_data;
   end

   // Upstream must hold off while full.
   a_no_overflow: assert property (@(posedge clk) disable iff (i_reset)
      i_valid |-> o_ready)
      else $error("sync_fifo write while full");

   // Downstream reads only while a word is held.
   a_no_underflow: assert property (@(posedge clk) disable iff (i_reset)
      i_ready |-> o_valid)
      else $error("sync_fifo read while empty");

endmodule

// ==== logic/cmd_if.sv ====
`timescale 1ns/100ps

interface cmd_if;

   logic                  valid;     // Head of queue holds a command.
   logic                  ready;     // Sequencer consumes the head.
   logic                  send_imm;
   logic                  chain;
   logic                  reload;
   logic                  stop;
   rx_ctrl_pkg::lines_t   num_lines;
   rx_ctrl_pkg::time_t    rx_time;
   logic                  halt;      // Level until flushed.
   logic                  flush;     // Clears queue and halt together.

   modport queue (
      output valid, send_imm, chain, reload, stop, num_lines, rx_time, halt,
      input  ready, flush
   );

   modport seq (
      input  valid, send_imm, chain, reload, stop, num_lines, rx_time, halt,
      output ready, flush
   );

endinterface

// ==== logic/err_pkt_pkg.sv ====
package err_pkt_pkg;

   typedef logic [31:0] err_code_t;
   typedef logic [11:0] seqnum_t;
   typedef logic [31:0] sid_t;

   // Codes placed in the upper half of the last beat.
   localparam err_code_t ERR_OVERRUN      = 32'd8;
   localparam err_code_t ERR_BROKEN_CHAIN = 32'd4;
   localparam err_code_t ERR_LATE_CMD     = 32'd2;

   // Header beat fields.
   localparam logic [3:0]  ERR_HDR_FLAGS = 4'hF;
   localparam logic [15:0] ERR_PKT_BYTES = 16'd24; // Three 8-byte beats.

   localparam int ERR_FIFO_LOG2 = 4; // 16 beats of buffering.

endpackage

// ==== logic/rx_ctrl_pkg.sv ====
package rx_ctrl_pkg;

   // Widths that carry a meaning on the command side.
   typedef logic [63:0] time_t;     // Radio time count.
   typedef logic [27:0] lines_t;    // Lines in one burst.
   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;

   // Stored command with the command word above the start time.
   typedef logic [95:0] cmd_word_t;

   // Settings bus map.
   localparam set_addr_t SET_ADDR_CMD     = 8'h10;
   localparam set_addr_t SET_ADDR_TIME_HI = 8'h11;
   localparam set_addr_t SET_ADDR_TIME_LO = 8'h12; // Enqueues the staged command.
   localparam set_addr_t SET_ADDR_HALT    = 8'h13;

   // Flag positions in the command word.
   localparam int CMD_BIT_IMM    = 31;
   localparam int CMD_BIT_CHAIN  = 30;
   localparam int CMD_BIT_RELOAD = 29;
   localparam int CMD_BIT_STOP   = 28;

   localparam int CMD_FIFO_LOG2 = 4; // 16 pending commands.

   // Burst sequencer states.
   typedef enum logic [1:0] {
      IDLE,
      RUNNING,
      ERR_WAIT
   } seq_state_t;

endpackage
